/* mem_pkg.sv */
package mem_pkg;

   // data path
   localparam int XLEN   = 32;   // data and byte address width
   localparam int CTRL_W = 3;    // {unsigned, size[1:0]}

   // size codes in ctrl[1:0]
   localparam logic [1:0] SIZE_BYTE = 2'd0;
   localparam logic [1:0] SIZE_HALF = 2'd1;
   localparam logic [1:0] SIZE_WORD = 2'd2;

   // ctrl bit that selects zero extension on loads
   localparam int CTRL_UNSIGNED_BIT = 2;

   // word memory geometry
   localparam int MEM_WORDS = 1024;
   localparam int MEM_AW    = 10;   // word index, byte address bits 11:2
   localparam int MASK_W    = 4;    // one bit per byte lane

   // memory busy timing, in clk cycles
   localparam int BUSY_CNT_W = 3;
   localparam logic [BUSY_CNT_W-1:0] MEM_LATENCY    = 3'd3;
   localparam logic [BUSY_CNT_W-1:0] REFRESH_CYCLES = 3'd4;

   // refresh timer
   // request after REFRESH_INTERVAL, late once the count passes REFRESH_LIMIT
   localparam int REFRESH_CNT_W = 10;
   localparam logic [REFRESH_CNT_W-1:0] REFRESH_INTERVAL = 10'd200;
   localparam logic [REFRESH_CNT_W-1:0] REFRESH_LIMIT    = 10'd405;

endpackage

/* mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
   input  logic                       clk,
   input  logic                       rst_x,
   input  logic                       i_rd_en,
   input  logic                       i_wr_en,
   input  logic [mem_pkg::XLEN-1:0]   i_addr,
   input  logic [mem_pkg::XLEN-1:0]   i_data,
   input  logic [mem_pkg::CTRL_W-1:0] i_ctrl,
   output logic [mem_pkg::XLEN-1:0]   o_data,
   output logic                       o_busy,
   output logic                       o_late_refresh
);

   logic                       w_mem_rd;
   logic                       w_mem_we;
   logic                       w_mem_refresh;
   logic [mem_pkg::MEM_AW-1:0] w_mem_addr;
   logic [mem_pkg::XLEN-1:0]   w_mem_wdata;
   logic [mem_pkg::MASK_W-1:0] w_mem_mask;
   logic [mem_pkg::XLEN-1:0]   w_mem_rdata;
   logic                       w_mem_busy;
   logic                       w_refresh_req;
   logic                       w_refresh_ack;

   unaligned_access_ctrl u_ctrl (
      .clk           (clk),
      .rst_x         (rst_x),
      .i_rd_en       (i_rd_en),
      .i_wr_en       (i_wr_en),
      .i_addr        (i_addr),
      .i_data        (i_data),
      .i_ctrl        (i_ctrl),
      .o_data        (o_data),
      .o_busy        (o_busy),
      .i_mem_rdata   (w_mem_rdata),
      .i_mem_busy    (w_mem_busy),
      .o_mem_rd      (w_mem_rd),
      .o_mem_we      (w_mem_we),
      .o_mem_addr    (w_mem_addr),
      .o_mem_wdata   (w_mem_wdata),
      .o_mem_mask    (w_mem_mask),
      .o_mem_refresh (w_mem_refresh),
      .i_refresh_req (w_refresh_req),
      .o_refresh_ack (w_refresh_ack)
   );

   refresh_timer u_refresh (
      .clk            (clk),
      .rst_x          (rst_x),
      .i_refresh_ack  (w_refresh_ack),
      .o_refresh_req  (w_refresh_req),
      .o_late_refresh (o_late_refresh)
   );

   word_mem u_mem (
      .clk       (clk),
      .rst_x     (rst_x),
      .i_rd      (w_mem_rd),
      .i_we      (w_mem_we),
      .i_refresh (w_mem_refresh),
      .i_addr    (w_mem_addr),
      .i_wdata   (w_mem_wdata),
      .i_mask    (w_mem_mask),
      .o_rdata   (w_mem_rdata),
      .o_busy    (w_mem_busy)
   );

endmodule

/* project.f */
mem_pkg.sv
refresh_timer.sv
word_mem.sv
unaligned_access_ctrl.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* refresh_timer.sv */
`timescale 1ns/1ps

module refresh_timer (
   input  logic clk,
   input  logic rst_x,
   input  logic i_refresh_ack,
   output logic o_refresh_req,
   output logic o_late_refresh
);

   logic [mem_pkg::REFRESH_CNT_W-1:0] r_cnt;

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_cnt          <= '0;
         o_late_refresh <= 1'b0;
      end else begin
         if (i_refresh_ack) begin
            r_cnt <= '0;
         end else if (r_cnt != '1) begin
            r_cnt <= r_cnt + 1'b1;   // saturates at all ones
         end
         if (r_cnt > mem_pkg::REFRESH_LIMIT) begin
            o_late_refresh <= 1'b1;   // sticky until reset
         end
      end
   end

   // held until the controller acknowledges
   assign o_refresh_req = (r_cnt >= mem_pkg::REFRESH_INTERVAL);

   // controller must only refresh on our request
   a_ack_with_req: assert property (@(posedge clk) disable iff (!rst_x)
      i_refresh_ack |-> o_refresh_req)
      else $error("refresh ack without pending request");

endmodule

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_mem_subsys
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mem_subsys 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

/* tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;

   localparam int CLK_PERIOD = 100;
   localparam int BA_W       = mem_pkg::MEM_AW + 2;   // byte address bits inside memory
   localparam int WAIT_LIMIT = 40;                    // cycles before an access counts as stuck

   localparam logic [2:0] C_BYTE   = {1'b0, mem_pkg::SIZE_BYTE};
   localparam logic [2:0] C_BYTE_U = {1'b1, mem_pkg::SIZE_BYTE};
   localparam logic [2:0] C_HALF   = {1'b0, mem_pkg::SIZE_HALF};
   localparam logic [2:0] C_HALF_U = {1'b1, mem_pkg::SIZE_HALF};
   localparam logic [2:0] C_WORD   = {1'b0, mem_pkg::SIZE_WORD};

   // accesses in the aligned, sub-word, boundary, idle reload and random tests
   localparam int N_ACCESS      = 8 + 40 + 48 + 4 + 200;
   localparam int ACCESS_CYCLES = 2 * int'(mem_pkg::MEM_LATENCY)
                                  + int'(mem_pkg::REFRESH_CYCLES) + 10;
   localparam int IDLE_CYCLES   = 3 * int'(mem_pkg::REFRESH_INTERVAL);
   localparam int WATCHDOG_CYC  = N_ACCESS * ACCESS_CYCLES + IDLE_CYCLES + 10;

   localparam logic [31:0] ALIGNED_ADDR [4] = '{32'h400, 32'h5a8, 32'h7fc, 32'hfff0_0e40};

   logic        clk;
   logic        rst_x;
   logic        i_rd_en;
   logic        i_wr_en;
   logic [31:0] i_addr;
   logic [31:0] i_data;
   logic [2:0]  i_ctrl;
   logic [31:0] o_data;
   logic        o_busy;
   logic        o_late_refresh;

   logic [7:0]  mem_model [2**BA_W];   // byte image of the word memory
   logic [31:0] rng;
   int          errors;

   mem_subsys_top u_dut (
      .clk            (clk),
      .rst_x          (rst_x),
      .i_rd_en        (i_rd_en),
      .i_wr_en        (i_wr_en),
      .i_addr         (i_addr),
      .i_data         (i_data),
      .i_ctrl         (i_ctrl),
      .o_data         (o_data),
      .o_busy         (o_busy),
      .o_late_refresh (o_late_refresh)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("timeout: run exceeded %0d clock cycles", WATCHDOG_CYC);
      $display("Testbench failed");
      $finish;
   end

   function automatic logic [31:0] lcg_next();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   // 1, 2 or 4 bytes from the size code
   function automatic int size_bytes(input logic [1:0] sz);
      return 1 << sz;
   endfunction

   // little endian gather from the byte model, wrapping at the memory end
   function automatic logic [31:0] model_load(input logic [31:0] addr, input logic [2:0] ctrl);
      logic [31:0]     v;
      logic [BA_W-1:0] idx;
      int              n;
      v = 32'h0;
      n = size_bytes(ctrl[1:0]);
      for (int i = 0; i < n; i++) begin
         idx = addr[BA_W-1:0] + BA_W'(i);
         v[8*i +: 8] = mem_model[idx];
      end
      if (!ctrl[mem_pkg::CTRL_UNSIGNED_BIT]) begin
         if (n == 1) v = {{24{v[7]}}, v[7:0]};
         else if (n == 2) v = {{16{v[15]}}, v[15:0]};
      end
      return v;
   endfunction

   task automatic run_access(input logic wr, input logic [31:0] addr,
                             input logic [31:0] data, input logic [2:0] ctrl);
      int n;
      n = 0;
      @(negedge clk);   // leaves one idle edge for refresh
      while (o_busy && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      assert (!o_busy) else begin
         $display("%0t: controller never went idle before a request", $time);
         errors++;
      end
      i_wr_en = wr;
      i_rd_en = !wr;
      i_addr  = addr;
      i_data  = data;
      i_ctrl  = ctrl;
      @(negedge clk);
      i_wr_en = 1'b0;
      i_rd_en = 1'b0;
      assert (o_busy) else begin
         $display("%0t: busy did not rise after a request", $time);
         errors++;
      end
      n = 0;
      while (o_busy && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      assert (!o_busy) else begin
         $display("%0t: access to %h did not complete", $time, addr);
         errors++;
      end
   endtask

   task automatic store_and_model(input logic [31:0] addr, input logic [31:0] data,
                                  input logic [2:0] ctrl);
      logic [BA_W-1:0] idx;
      run_access(1'b1, addr, data, ctrl);
      for (int i = 0; i < size_bytes(ctrl[1:0]); i++) begin
         idx = addr[BA_W-1:0] + BA_W'(i);
         mem_model[idx] = data[8*i +: 8];
      end
   endtask

   task automatic load_and_compare(input logic [31:0] addr, input logic [2:0] ctrl);
      logic [31:0] exp;
      run_access(1'b0, addr, 32'h0, ctrl);
      exp = model_load(addr, ctrl);
      assert (o_data === exp) else begin
         $display("MISMATCH %0t: load %h ctrl %b expected %h got %h",
                  $time, addr, ctrl, exp, o_data);
         errors++;
      end
   endtask

   task automatic aligned_word_rw();
      for (int i = 0; i < 4; i++) store_and_model(ALIGNED_ADDR[i], lcg_next(), C_WORD);
      for (int i = 0; i < 4; i++) load_and_compare(ALIGNED_ADDR[i], C_WORD);
   endtask

   task automatic sub_word_offsets();
      logic [31:0] a;
      for (int off = 0; off < 4; off++) begin
         a = 32'h800 + 32'(off);
         store_and_model(32'h800, lcg_next(), C_WORD);
         store_and_model(a, lcg_next() | 32'h80, C_BYTE);   // top bit set for sign checks
         load_and_compare(a, C_BYTE);
         load_and_compare(a, C_BYTE_U);
         load_and_compare(32'h800, C_WORD);
         store_and_model(a, lcg_next() | 32'h8000, C_HALF);
         load_and_compare(a, C_HALF);
         load_and_compare(a, C_HALF_U);
         load_and_compare(32'h800, C_WORD);
         load_and_compare(32'h804, C_WORD);   // offset 3 spills here
      end
   endtask

   task automatic check_cross(input logic [31:0] base, input logic [31:0] off,
                              input logic [2:0] ctrl);
      store_and_model(base, lcg_next(), C_WORD);
      store_and_model(base + 4, lcg_next(), C_WORD);
      store_and_model(base + off, lcg_next(), ctrl);
      load_and_compare(base + off, ctrl);
      load_and_compare(base, C_WORD);
      load_and_compare(base + 4, C_WORD);
   endtask

   task automatic boundary_cross();
      logic [31:0] base;
      for (int b = 0; b < 2; b++) begin
         base = (b == 0) ? 32'hc00 : 32'hffc;   // last word wraps to word 0
         check_cross(base, 32'd3, C_HALF);
         check_cross(base, 32'd1, C_WORD);
         check_cross(base, 32'd2, C_WORD);
         check_cross(base, 32'd3, C_WORD);
      end
   endtask

   task automatic idle_refresh();
      int   rises;
      logic prev;
      rises = 0;
      prev  = o_busy;
      for (int c = 0; c < IDLE_CYCLES; c++) begin
         @(negedge clk);
         if (o_busy && !prev) rises++;
         prev = o_busy;
      end
      assert (rises >= 2) else begin
         $display("refresh ran only %0d times while idle", rises);
         errors++;
      end
      assert (!o_late_refresh) else begin
         $display("late refresh flag set while idle");
         errors++;
      end
      for (int i = 0; i < 4; i++) load_and_compare(ALIGNED_ADDR[i], C_WORD);
   endtask

   task automatic random_traffic();
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] r;
      logic [2:0]  ctrl;
      for (int k = 0; k < 200; k++) begin
         addr = lcg_next();   // full range, upper bits wrap
         data = lcg_next();
         r    = lcg_next();
         ctrl = {r[7], 2'(r[31:16] % 16'd3)};
         if (r[12]) store_and_model(addr, data, ctrl);
         else load_and_compare(addr, ctrl);
      end
      assert (!o_late_refresh) else begin
         $display("late refresh flag set after random traffic");
         errors++;
      end
   endtask

   initial begin
      errors  = 0;
      rng     = 32'h8af259c3;
      rst_x   = 1'b0;
      i_rd_en = 1'b0;
      i_wr_en = 1'b0;
      i_addr  = 32'h0;
      i_data  = 32'h0;
      i_ctrl  = 3'h0;
      for (int i = 0; i < 2**BA_W; i++) mem_model[i] = 8'h00;
      repeat (2) @(negedge clk);
      rst_x = 1'b1;
      aligned_word_rw();
      sub_word_offsets();
      boundary_cross();
      idle_refresh();
      random_traffic();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* unaligned_access_ctrl.sv */
`timescale 1ns/1ps

module unaligned_access_ctrl (
   input  logic                       clk,
   input  logic                       rst_x,
   // user side
   input  logic                       i_rd_en,
   input  logic                       i_wr_en,
   input  logic [mem_pkg::XLEN-1:0]   i_addr,
   input  logic [mem_pkg::XLEN-1:0]   i_data,
   input  logic [mem_pkg::CTRL_W-1:0] i_ctrl,
   output logic [mem_pkg::XLEN-1:0]   o_data,
   output logic                       o_busy,
   // word memory side
   input  logic [mem_pkg::XLEN-1:0]   i_mem_rdata,
   input  logic                       i_mem_busy,
   output logic                       o_mem_rd,
   output logic                       o_mem_we,
   output logic [mem_pkg::MEM_AW-1:0] o_mem_addr,
   output logic [mem_pkg::XLEN-1:0]   o_mem_wdata,
   output logic [mem_pkg::MASK_W-1:0] o_mem_mask,
   output logic                       o_mem_refresh,
   // refresh timer
   input  logic                       i_refresh_req,
   output logic                       o_refresh_ack
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_ISSUE1,     // first word strobe
      S_WAIT1,
      S_ISSUE2,     // next word, spilled bytes only
      S_WAIT2,
      S_REF_WAIT
   } state_t;

   state_t r_state;

   // latched request
   logic                          r_wr;
   logic [1:0]                    r_off;
   logic [mem_pkg::CTRL_W-1:0]    r_ctrl;
   logic [mem_pkg::MEM_AW-1:0]    r_widx;
   logic [2*mem_pkg::XLEN-1:0]    r_wdata;   // store data shifted across two words
   logic [2*mem_pkg::MASK_W-1:0]  r_mask;    // byte mask across two words
   logic [mem_pkg::XLEN-1:0]      r_rdata1;  // first word of a split load

   logic                          w_accept;
   logic                          w_two;
   logic                          w_load_done;
   logic [mem_pkg::XLEN-1:0]      w_sized;
   logic [mem_pkg::MASK_W-1:0]    w_size_mask;
   logic [mem_pkg::XLEN-1:0]      w_lo;
   logic [mem_pkg::XLEN-9:0]      w_hi;
   logic [2*mem_pkg::XLEN-9:0]    w_merged;
   logic [mem_pkg::XLEN-1:0]      w_load_val;

   assign w_accept = (r_state == S_IDLE) && (i_rd_en || i_wr_en);
   assign w_two    = (r_mask[2*mem_pkg::MASK_W-1:mem_pkg::MASK_W] != '0);

   // trim store data and build the lane mask by size
   always_comb begin
      case (i_ctrl[1:0])
         mem_pkg::SIZE_BYTE: begin
            w_sized     = {24'h0, i_data[7:0]};
            w_size_mask = 4'b0001;
         end
         mem_pkg::SIZE_HALF: begin
            w_sized     = {16'h0, i_data[15:0]};
            w_size_mask = 4'b0011;
         end
         default: begin
            w_sized     = i_data;
            w_size_mask = 4'b1111;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_state <= S_IDLE;
      end else begin
         case (r_state)
            S_IDLE: begin
               if (i_rd_en || i_wr_en) begin
                  r_state <= S_ISSUE1;
               end else if (i_refresh_req) begin
                  r_state <= S_REF_WAIT;   // refresh only when no user request
               end
            end
            S_ISSUE1: r_state <= S_WAIT1;
            S_WAIT1: begin
               if (!i_mem_busy) begin
                  r_state <= w_two ? S_ISSUE2 : S_IDLE;
               end
            end
            S_ISSUE2: r_state <= S_WAIT2;
            S_WAIT2: begin
               if (!i_mem_busy) begin
                  r_state <= S_IDLE;
               end
            end
            S_REF_WAIT: begin
               if (!i_mem_busy) begin
                  r_state <= S_IDLE;
               end
            end
            default: r_state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (w_accept) begin
         r_wr    <= !i_rd_en;   // read wins a double strobe
         r_off   <= i_addr[1:0];
         r_ctrl  <= i_ctrl;
         r_widx  <= i_addr[mem_pkg::MEM_AW+1:2];
         r_wdata <= {32'h0, w_sized} << {i_addr[1:0], 3'b000};
         r_mask  <= {4'b0000, w_size_mask} << i_addr[1:0];
      end else if (r_state == S_WAIT1 && !i_mem_busy) begin
         r_widx   <= r_widx + 1'b1;   // wraps past the last word
         r_rdata1 <= i_mem_rdata;
      end
   end

   // ISSUE states and IDLE are entered only once the memory is free
   assign o_mem_rd      = (r_state == S_ISSUE1 || r_state == S_ISSUE2) && !r_wr;
   assign o_mem_we      = (r_state == S_ISSUE1 || r_state == S_ISSUE2) && r_wr;
   assign o_mem_refresh = (r_state == S_IDLE) && !i_rd_en && !i_wr_en && i_refresh_req;
   assign o_refresh_ack = o_mem_refresh;
   assign o_mem_addr    = r_widx;
   assign o_mem_wdata   = (r_state == S_ISSUE2) ? r_wdata[63:32] : r_wdata[31:0];
   assign o_mem_mask    = (r_state == S_ISSUE2) ? r_mask[7:4] : r_mask[3:0];

   assign o_busy = (r_state != S_IDLE);

   // first word merged with the low three bytes of the next one
   assign w_lo     = (r_state == S_WAIT2) ? r_rdata1 : i_mem_rdata;
   assign w_hi     = (r_state == S_WAIT2) ? i_mem_rdata[23:0] : 24'h0;
   assign w_merged = {w_hi, w_lo} >> {r_off, 3'b000};

   always_comb begin
      case (r_ctrl[1:0])
         mem_pkg::SIZE_BYTE: begin
            if (r_ctrl[mem_pkg::CTRL_UNSIGNED_BIT]) begin
               w_load_val = {24'h0, w_merged[7:0]};
            end else begin
               w_load_val = {{24{w_merged[7]}}, w_merged[7:0]};
            end
         end
         mem_pkg::SIZE_HALF: begin
            if (r_ctrl[mem_pkg::CTRL_UNSIGNED_BIT]) begin
               w_load_val = {16'h0, w_merged[15:0]};
            end else begin
               w_load_val = {{16{w_merged[15]}}, w_merged[15:0]};
            end
         end
         default: w_load_val = w_merged[31:0];
      endcase
   end

   assign w_load_done = !i_mem_busy && !r_wr &&
                        ((r_state == S_WAIT1 && !w_two) || r_state == S_WAIT2);

   // held until the next load completes
   always_ff @(posedge clk) begin
      if (w_load_done) begin
         o_data <= w_load_val;
      end
   end

   // FSM must only strobe into a free memory
   a_mem_free: assert property (@(posedge clk) disable iff (!rst_x)
      (o_mem_rd || o_mem_we || o_mem_refresh) |-> !i_mem_busy)
      else $error("memory strobe while memory busy");

   a_user_proto: assert property (@(posedge clk) disable iff (!rst_x)
      (i_rd_en || i_wr_en) |-> !o_busy)
      else $error("user strobe while controller busy");

endmodule

/* word_mem.sv */
`timescale 1ns/1ps

module word_mem (
   input  logic                       clk,
   input  logic                       rst_x,
   input  logic                       i_rd,
   input  logic                       i_we,
   input  logic                       i_refresh,
   input  logic [mem_pkg::MEM_AW-1:0] i_addr,
   input  logic [mem_pkg::XLEN-1:0]   i_wdata,
   input  logic [mem_pkg::MASK_W-1:0] i_mask,
   output logic [mem_pkg::XLEN-1:0]   o_rdata,
   output logic                       o_busy
);

   logic [mem_pkg::XLEN-1:0]       r_mem [mem_pkg::MEM_WORDS];
   logic [mem_pkg::XLEN-1:0]       r_rd_hold;   // word read at acceptance
   logic [mem_pkg::BUSY_CNT_W-1:0] r_busy_cnt;

   // array, byte lane writes and busy counter
   always_ff @(posedge clk) begin
      if (!rst_x) begin
         for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            r_mem[i] <= '0;
         end
         r_busy_cnt <= '0;
      end else begin
         if (i_we) begin
            for (int b = 0; b < mem_pkg::MASK_W; b++) begin
               if (i_mask[b]) begin
                  r_mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
               end
            end
         end
         if (i_rd || i_we) begin
            r_busy_cnt <= mem_pkg::MEM_LATENCY;
         end else if (i_refresh) begin
            r_busy_cnt <= mem_pkg::REFRESH_CYCLES;   // refresh holds the array longer
         end else if (r_busy_cnt != '0) begin
            r_busy_cnt <= r_busy_cnt - 1'b1;
         end
      end
   end

   // read data shows up on the output only as busy ends
   always_ff @(posedge clk) begin
      if (i_rd) begin
         r_rd_hold <= r_mem[i_addr];
      end
      if (r_busy_cnt == 1) begin
         o_rdata <= r_rd_hold;
      end
   end

   assign o_busy = (r_busy_cnt != '0);

   a_one_cmd: assert property (@(posedge clk) disable iff (!rst_x)
      $onehot0({i_rd, i_we, i_refresh}))
      else $error("more than one memory command in a cycle");

   a_cmd_not_busy: assert property (@(posedge clk) disable iff (!rst_x)
      (i_rd || i_we || i_refresh) |-> !o_busy)
      else $error("memory command while busy");

endmodule
